// File: run.sh
#!/bin/sh
# Build and run the KSZ8851 bus master simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbKszBus -f vlog.f -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simv 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Regression passed"; then
    exit 0
fi
exit 1

// File: tb/kszChipModel.sv
/*
 * KSZ8851 bus-side behavioral model
 * Resolves the split data bus, keeps 256 register bytes and a DMA
 * word queue, counts reset pulses and flags accesses during reset
 */

`timescale 1ns/1ps

module kszChipModel (
    input  logic        sysclk,
    input  logic        reset,
    input  logic        ethRstn,
    input  logic        ethCmd,
    input  logic        ethRdn,
    input  logic        ethWrn,
    input  logic [15:0] sdOut,
    input  logic        sdOe,
    output logic [15:0] sdIn,
    output int          rstPulses,      // Rising edges of ethRstn
    output int          accessCount,    // Strobe falls seen
    output logic        accessErr       // Strobe while chip held in reset
);

    logic [7:0]  regs [256];
    logic [15:0] dmaMem [256];          // DMA queue storage
    logic [7:0]  dmaWr;
    logic [7:0]  dmaRd;
    logic [15:0] addrWord;              // Last address cycle, enables and offset
    logic        addrFresh;             // Next data access is a register access
    logic [7:0]  base;                  // 32-bit aligned chunk of the offset
    logic [15:0] busVal;
    logic        prevWrn;
    logic        prevRdn;
    logic        prevRstn;

    assign base   = {addrWord[7:2], 2'b00};
    assign busVal = sdOe ? sdOut : sdIn;    // Bus resolution

    // Chip drives only while the read strobe is low
    always_comb begin
        sdIn = '0;
        if (!ethRdn) begin
            if (addrFresh) begin
                if (addrWord[12]) sdIn[7:0]  = regs[base];
                if (addrWord[13]) sdIn[15:8] = regs[8'(base + 8'd1)];
                if (addrWord[14]) sdIn[7:0]  = regs[8'(base + 8'd2)];
                if (addrWord[15]) sdIn[15:8] = regs[8'(base + 8'd3)];
            end else begin
                sdIn = dmaMem[dmaRd];       // Head of DMA queue
            end
        end
    end

    always @(posedge sysclk or negedge reset) begin
        if (!reset) begin
            for (int a = 0; a < 256; a++) begin
                regs[a] <= 8'(a) ^ 8'h5A;   // Fill pattern from address
            end
            dmaWr       <= '0;
            dmaRd       <= '0;
            addrWord    <= '0;
            addrFresh   <= 1'b0;
            prevWrn     <= 1'b1;
            prevRdn     <= 1'b1;
            prevRstn    <= 1'b0;
            rstPulses   <= 0;
            accessCount <= 0;
            accessErr   <= 1'b0;
        end else begin
            prevWrn  <= ethWrn;
            prevRdn  <= ethRdn;
            prevRstn <= ethRstn;
            if (ethRstn && !prevRstn) rstPulses <= rstPulses + 1;
            if ((!ethWrn && prevWrn) || (!ethRdn && prevRdn)) begin
                accessCount <= accessCount + 1;
            end
            if (!ethRstn && (!ethWrn || !ethRdn)) accessErr <= 1'b1;

            // Write strobe release latches the bus
            if (ethWrn && !prevWrn) begin
                if (ethCmd) begin
                    addrWord  <= busVal;
                    addrFresh <= 1'b1;
                end else if (addrFresh) begin
                    if (addrWord[12]) regs[base] <= busVal[7:0];
                    if (addrWord[13]) regs[8'(base + 8'd1)] <= busVal[15:8];
                    if (addrWord[14]) regs[8'(base + 8'd2)] <= busVal[7:0];
                    if (addrWord[15]) regs[8'(base + 8'd3)] <= busVal[15:8];
                    addrFresh <= 1'b0;
                end else begin
                    dmaMem[dmaWr] <= busVal;    // DMA append
                    dmaWr         <= dmaWr + 8'd1;
                end
            end
            // Read strobe release ends the access
            if (ethRdn && !prevRdn) begin
                if (addrFresh) addrFresh <= 1'b0;
                else dmaRd <= dmaRd + 8'd1;     // DMA pop
            end
        end
    end

endmodule

// File: tb/tbKszBus.sv
/*
 * KSZ8851 bus master testbench
 * Drives host words, checks read results against a shadow model,
 * watches reset timing, illegal words and FIFO back-pressure
 */

`timescale 1ns/1ps

module tbKszBus import kszPkg::*; ();

    localparam int RstAssert     = 20;
    localparam int RstWait       = 40;
    localparam int NumCmds       = 80;      // Upper bound over all phases
    localparam int TimeoutCycles = (NumCmds * 11 + 2 * (RstAssert + RstWait)) * 4;

    logic        sysclk = 1'b0;
    logic        reset;
    logic        hostValid;
    logic        hostReady;
    logic [31:0] hostWord;
    logic        rspValid;
    logic        rspReady = 1'b0;
    kszRsp_t     rsp;
    logic        chipReady;
    logic        badCmd;
    logic        ethRstn, ethCmd, ethRdn, ethWrn, sdOe;
    logic [15:0] sdOut, sdIn;
    int          rstPulses, accessCount;
    logic        accessErr;

    logic [7:0]  shadowRegs [256];          // Expected chip register bytes
    logic [15:0] shadowDma [$];             // Expected DMA queue
    logic [16:0] expQ [$];                  // Pending responses {rdData, wasDma}
    logic [16:0] expNow;
    int          cycles = 0;
    int          highCnt, wakeCount;
    logic        afterRst, prevChip, inBurst, sawFull;

    always #2 sysclk = !sysclk;             // 4 ns period

    kszBusTop #(
        .ResetAssertCycles (RstAssert),
        .ResetWaitCycles   (RstWait)
    ) kszBusTop_i (
        .sysclk, .reset, .hostValid, .hostReady, .hostWord,
        .rspValid, .rspReady, .rsp, .chipReady, .badCmd,
        .ethRstn, .ethCmd, .ethRdn, .ethWrn, .sdOut, .sdOe, .sdIn
    );

    kszChipModel chip_i (
        .sysclk, .reset, .ethRstn, .ethCmd, .ethRdn, .ethWrn,
        .sdOut, .sdOe, .sdIn, .rstPulses, .accessCount, .accessErr
    );

    // ------------------------------------------------------------------------
    // Reporting
    // ------------------------------------------------------------------------
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "Run stopped");
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] hostCmd(input logic dma, input logic rst, input logic wr,
                                            input logic word, input logic [7:0] offs,
                                            input logic [15:0] data);
        return {4'h0, dma, rst, wr, word, offs, data};
    endfunction

    // Returns 1 when a response is due, updates the shadow on writes
    function automatic logic refResult(input logic [31:0] w, output logic [16:0] exp);
        logic [7:0] o;
        logic       isWord;
        logic       isWr;
        o      = w[23:16];
        isWord = w[24];
        isWr   = w[25];
        exp    = '0;
        if (w[31:28] != 4'h0 || w[26]) return 1'b0;    // Illegal or chip reset
        if (w[27]) begin
            if (isWr) begin
                shadowDma.push_back(w[15:0]);
                return 1'b0;
            end
            exp = {shadowDma.pop_front(), 1'b1};
            return 1'b1;
        end
        if (isWord && o[0]) return 1'b0;               // Odd word offset dropped
        if (isWr) begin
            if (isWord) begin
                shadowRegs[o]            = w[7:0];
                shadowRegs[8'(o + 8'd1)] = w[15:8];
            end else begin
                shadowRegs[o] = o[0] ? w[15:8] : w[7:0];   // Odd bytes on upper lane
            end
            return 1'b0;
        end
        if (isWord) exp = {shadowRegs[8'(o + 8'd1)], shadowRegs[o], 1'b0};
        else if (o[0]) exp = {shadowRegs[o], 8'h00, 1'b0};
        else exp = {8'h00, shadowRegs[o], 1'b0};
        return 1'b1;
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus tasks, entered and left 1 ns after a rising edge
    // ------------------------------------------------------------------------
    task automatic issue(input logic [31:0] w);
        logic [16:0] e;
        logic        taken;
        if (refResult(w, e)) expQ.push_back(e);
        hostValid = 1'b1;
        hostWord  = w;
        do begin
            @(negedge sysclk);
            taken = hostReady;      // Stable until the next edge
            @(posedge sysclk);
        end while (!taken);
        #1;
        hostValid = 1'b0;
    endtask

    task automatic drainRsp();
        do @(negedge sysclk); while (expQ.size() != 0 || !chipReady);
        @(posedge sysclk);
        #1;
    endtask

    // Random response back-pressure
    always @(posedge sysclk) begin
        #1;
        rspReady = 1'(($urandom % 2));
    end

    // Response comparison
    always @(negedge sysclk) begin
        if (reset && rspValid && rspReady) begin
            if (expQ.size() == 0) abortRun("A response arrived with no read outstanding");
            expNow = expQ.pop_front();
            checkEq("rsp", 32'(rsp), 32'(expNow));
        end
    end

    // Reset timing and back-pressure monitor
    always @(negedge sysclk) begin
        if (!reset) begin
            highCnt   = 0;
            wakeCount = 0;
            afterRst  = 1'b1;
            prevChip  = 1'b0;
            sawFull   = 1'b0;
        end else begin
            if (!ethRstn) begin
                highCnt  = 0;
                afterRst = 1'b1;
                if (chipReady) abortRun("chipReady was high while the chip was in reset");
            end else begin
                highCnt++;
            end
            // Count includes the cycle where chipReady is first seen high
            if (chipReady && !prevChip && afterRst) begin
                if (highCnt <= RstWait) begin
                    abortRun("chipReady rose before the wake-up wait ended");
                end
                afterRst = 1'b0;
                wakeCount++;
            end
            if (inBurst && hostValid && !hostReady) sawFull = 1'b1;
            prevChip = chipReady;
        end
    end

    // Watchdog
    always @(posedge sysclk) begin
        cycles++;
        if (cycles >= TimeoutCycles) abortRun("Timeout, the DUT stopped making progress");
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [7:0]  wOffs [16];
        logic [7:0]  o;
        logic        wd;
        int          a0, p0;
        void'($urandom(27));
        reset     = 1'b0;
        hostValid = 1'b0;
        hostWord  = '0;
        inBurst   = 1'b0;
        for (int a = 0; a < 256; a++) shadowRegs[a] = 8'(a) ^ 8'h5A;
        repeat (16) @(posedge sysclk);
        #1 reset = 1'b1;
        drainRsp();                                         // Wake-up sequence
        checkEq("rstPulses", rstPulses, 1);

        // Register writes then reads
        for (int i = 0; i < 16; i++) begin
            o  = 8'($urandom);
            wd = 1'($urandom % 2);
            if (wd) o[0] = 1'b0;
            wOffs[i] = o;
            issue(hostCmd(1'b0, 1'b0, 1'b1, wd, o, 16'($urandom)));
        end
        for (int i = 0; i < 16; i++) begin
            wd = 1'($urandom % 2) && !wOffs[i][0];
            issue(hostCmd(1'b0, 1'b0, 1'b0, wd, wOffs[i], 16'h0));
        end
        drainRsp();

        // DMA writes then reads
        for (int i = 0; i < 8; i++) issue(hostCmd(1'b1, 1'b0, 1'b1, 1'b1, 8'h0, 16'($urandom)));
        for (int i = 0; i < 8; i++) issue(hostCmd(1'b1, 1'b0, 1'b0, 1'b1, 8'h0, 16'h0));
        drainRsp();

        // Illegal host words
        a0 = accessCount;
        checkEq("badCmd", 32'(badCmd), 0);
        issue(32'h3000_1234 | hostCmd(1'b0, 1'b0, 1'b0, 1'b0, 8'h10, 16'h0));
        checkEq("badCmd", 32'(badCmd), 1);
        issue(hostCmd(1'b0, 1'b0, 1'b0, 1'b1, 8'h23, 16'h0));  // Word at odd offset
        issue(hostCmd(1'b0, 1'b0, 1'b0, 1'b1, 8'h22, 16'h0));
        drainRsp();
        checkEq("accessCount", accessCount, a0 + 2);       // Address and read strobe of the legal read
        checkEq("badCmd", 32'(badCmd), 1);

        // Burst longer than both FIFOs
        inBurst = 1'b1;
        for (int i = 0; i < 20; i++) begin
            o  = 8'($urandom);
            wd = 1'($urandom % 2) && !o[0];
            issue(hostCmd(1'b0, 1'b0, 1'b0, wd, o, 16'h0));
        end
        drainRsp();
        inBurst = 1'b0;
        checkEq("sawFull", 32'(sawFull), 1);

        // Chip reset with commands queued behind it
        p0 = rstPulses;
        issue(hostCmd(1'b0, 1'b1, 1'b0, 1'b0, 8'h0, 16'h0));
        issue(hostCmd(1'b0, 1'b0, 1'b1, 1'b1, 8'h40, 16'hBEEF));
        issue(hostCmd(1'b0, 1'b0, 1'b0, 1'b1, 8'h40, 16'h0));
        issue(hostCmd(1'b1, 1'b0, 1'b1, 1'b1, 8'h0, 16'hC0DE));
        issue(hostCmd(1'b1, 1'b0, 1'b0, 1'b1, 8'h0, 16'h0));
        drainRsp();
        checkEq("rstPulses", rstPulses, p0 + 1);
        checkEq("wakeCount", wakeCount, 2);
        checkEq("accessErr", 32'(accessErr), 0);

        $display("Regression passed");
        $finish;
    end

endmodule

// File: verilog/hostCmdDecode.sv
/*
 * Host command decoder
 * Splits a 32-bit host word into a typed bus command.
 * Words with reserved bits set or odd word offsets are
 * accepted, dropped and recorded in a sticky error flag
 */

`timescale 1ns/1ps

module hostCmdDecode import kszPkg::*; (
    input  logic                    sysclk,
    input  logic                    reset,

    input  logic                    hostValid,
    input  logic [HostWordBits-1:0] hostWord,
    output logic                    hostReady,

    output logic                    cmdValid,
    output kszCmd_t                 cmd,
    input  logic                    cmdReady,

    output logic                    badCmd      // Sticky illegal word flag
);

    logic rsvdSet;      // Any reserved bit high
    logic oddWord;      // Word register access on odd offset
    logic illegal;

    // Field split, reset wins over DMA
    always_comb begin
        if (hostWord[ChipRstBit]) begin
            cmd.op = opChipReset;
        end else if (hostWord[DmaBit]) begin
            cmd.op = opDma;
        end else begin
            cmd.op = opReg;
        end
        cmd.isWrite = hostWord[WriteBit];
        cmd.isWord  = hostWord[WordBit];
        cmd.regAddr = hostWord[OffsMsb:OffsLsb];
        cmd.data    = hostWord[DataMsb:DataLsb];
    end

    assign rsvdSet = |hostWord[RsvdMsb:RsvdLsb];
    assign oddWord = (cmd.op == opReg) && cmd.isWord && cmd.regAddr[0];
    assign illegal = rsvdSet || oddWord;

    // Straight pass-through of the FIFO handshake
    assign hostReady = cmdReady;            // Illegal words drain at FIFO pace
    assign cmdValid  = hostValid && !illegal;

    // Error flag, set on the edge that swallows an illegal word
    always_ff @(posedge sysclk or negedge reset) begin
        if (!reset) begin
            badCmd <= 1'b0;
        end else if (hostValid && hostReady && illegal) begin
            badCmd <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    // A stalled command must reach the FIFO unchanged
    cmdHeld: assert property (
        @(posedge sysclk) disable iff (!reset)
        cmdValid && !cmdReady |=> cmdValid && $stable(cmd)
    );

endmodule

// File: verilog/kszBusCtrl.sv
/*
 * KSZ8851 bus controller
 * Runs one command at a time on the 16-bit multiplexed bus:
 * chip reset pulse and wake-up wait, address cycle with byte
 * enables, register and DMA reads and writes.
 * Read results leave on a valid/ready response port
 */

`timescale 1ns/1ps

module kszBusCtrl import kszPkg::*; #(
    parameter int ResetAssertCycles = 491520,   // ethRstn low time
    parameter int ResetWaitCycles   = 2097151   // Wait before first access
) (
    input  logic        sysclk,
    input  logic        reset,

    input  logic        cmdValid,
    input  kszCmd_t     cmd,
    output logic        cmdReady,

    output logic        rspValid,
    output kszRsp_t     rsp,
    input  logic        rspReady,

    output logic        chipReady,

    // Chip pins
    output logic        ethRstn,    // Chip reset, active low
    output logic        ethCmd,     // 1 address, 0 data
    output logic        ethRdn,     // Read strobe
    output logic        ethWrn,     // Write strobe
    output logic [15:0] sdOut,
    output logic        sdOe,
    input  logic [15:0] sdIn
);

    localparam int CntTop = (ResetAssertCycles > ResetWaitCycles) ?
                            ResetAssertCycles : ResetWaitCycles;
    localparam int CntW   = $clog2(CntTop + 1);

    typedef enum logic [3:0] {
        stResetAssert, stResetWait, stIdle,
        stAddrStart, stAddrHold, stAddrEnd,
        stWriteStart, stWriteHold, stWriteEnd,
        stReadStart, stReadHold, stReadEnd
    } state_t;

    state_t          state;
    logic [CntW-1:0] cnt;           // Reset timing
    logic            phase;         // Second cycle of two-cycle steps
    logic            accept;

    // Latched command
    logic            wrReg;
    logic            wordReg;
    logic            dmaReg;
    logic [7:0]      offsReg;
    logic [15:0]     dataReg;

    // ------------------------------------------------------------------------
    // Offset to bus address, 16-bit mode splits I/O space in 32-bit chunks
    // ------------------------------------------------------------------------
    function automatic logic [15:0] busAddr(input logic [7:0] offs, input logic word);
        logic [15:0] a;
        a       = '0;
        a[7:0]  = offs;
        a[12]   = (offs[1:0] == 2'd0);                              // BE0
        a[13]   = (!word && offs[1:0] == 2'd1) || (word && offs[1:0] == 2'd0);
        a[14]   = (offs[1:0] == 2'd2);                              // BE2
        a[15]   = (!word && offs[1:0] == 2'd3) || (word && offs[1:0] == 2'd2);
        return a;
    endfunction

    assign cmdReady  = (state == stIdle);
    assign chipReady = (state == stIdle);   // Idle only reached after wake-up
    assign accept    = cmdValid && cmdReady;
    assign sdOe      = ethRdn && ethRstn;   // Release bus while chip drives or sleeps

    // Control FSM
    always_ff @(posedge sysclk or negedge reset) begin
        if (!reset) begin
            state    <= stResetAssert;
            cnt      <= '0;
            phase    <= 1'b0;
            ethRstn  <= 1'b0;
            ethCmd   <= 1'b0;
            ethRdn   <= 1'b1;
            ethWrn   <= 1'b1;
            sdOut    <= '0;
            rspValid <= 1'b0;
        end else begin
            case (state)
                stResetAssert: begin
                    if (cnt == CntW'(ResetAssertCycles - 1)) begin
                        ethRstn <= 1'b1;        // Release chip
                        cnt     <= '0;
                        state   <= stResetWait;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                stResetWait: begin
                    if (cnt == CntW'(ResetWaitCycles - 1)) begin
                        cnt   <= '0;
                        state <= stIdle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                stIdle: begin
                    if (accept) begin
                        phase <= 1'b0;
                        case (cmd.op)
                            opChipReset: begin
                                ethRstn <= 1'b0;
                                cnt     <= '0;
                                state   <= stResetAssert;
                            end
                            opDma: begin
                                ethCmd <= 1'b0;     // No address cycle
                                state  <= cmd.isWrite ? stWriteStart : stReadStart;
                            end
                            default: begin
                                ethCmd <= 1'b1;
                                state  <= stAddrStart;
                            end
                        endcase
                    end
                end

                // Address cycle, 6 cycles
                stAddrStart: begin
                    if (!phase) begin
                        sdOut <= busAddr(offsReg, wordReg);
                        phase <= 1'b1;
                    end else begin
                        ethWrn <= 1'b0;
                        phase  <= 1'b0;
                        state  <= stAddrHold;
                    end
                end
                stAddrHold: begin
                    phase <= !phase;
                    if (phase) state <= stAddrEnd;
                end
                stAddrEnd: begin
                    if (!phase) begin
                        ethWrn <= 1'b1;     // Chip latches address here
                        phase  <= 1'b1;
                    end else begin
                        ethCmd <= 1'b0;
                        phase  <= 1'b0;
                        state  <= wrReg ? stWriteStart : stReadStart;
                    end
                end

                // Write data, 4 cycles
                stWriteStart: begin
                    if (!phase) begin
                        sdOut <= dataReg;
                        phase <= 1'b1;
                    end else begin
                        ethWrn <= 1'b0;
                        phase  <= 1'b0;
                        state  <= stWriteHold;
                    end
                end
                stWriteHold: state <= stWriteEnd;
                stWriteEnd: begin
                    ethWrn <= 1'b1;
                    state  <= stIdle;
                end

                // Read data, 5 cycles unless the response stalls
                stReadStart: begin
                    ethRdn <= 1'b0;
                    state  <= stReadHold;
                end
                stReadHold: begin
                    phase <= !phase;
                    if (phase) state <= stReadEnd;
                end
                stReadEnd: begin
                    if (!phase) begin
                        rspValid <= 1'b1;   // Data captured this edge
                        phase    <= 1'b1;
                    end else if (rspReady) begin
                        rspValid <= 1'b0;
                        ethRdn   <= 1'b1;
                        phase    <= 1'b0;
                        state    <= stIdle;
                    end
                end
                default: state <= stResetAssert;
            endcase
        end
    end

    // Payload latches
    always_ff @(posedge sysclk) begin
        if (accept) begin
            wrReg   <= cmd.isWrite;
            wordReg <= cmd.isWord;
            dmaReg  <= (cmd.op == opDma);
            offsReg <= cmd.regAddr;
            dataReg <= cmd.data;
        end
        if (state == stReadEnd && !phase) begin
            rsp.rdData <= sdIn;     // Third cycle of ethRdn low
            rsp.wasDma <= dmaReg;
        end
    end

    // ------------------------------------------------------------------------
    // Strobe checks
    // ------------------------------------------------------------------------
    strobeExcl: assert property (
        @(posedge sysclk) disable iff (!reset) ethRdn || ethWrn
    );
    wrnWidth: assert property (
        @(posedge sysclk) disable iff (!reset) $fell(ethWrn) |=> !ethWrn
    );

endmodule

// File: verilog/kszBusTop.sv
/*
 * KSZ8851 bus master top
 * Host words go through the decoder into a command FIFO,
 * the bus controller executes them in order and read
 * results come back through a response FIFO
 */

`timescale 1ns/1ps

module kszBusTop import kszPkg::*; #(
    parameter int CmdDepth          = 8,
    parameter int RspDepth          = 4,
    parameter int ResetAssertCycles = 491520,
    parameter int ResetWaitCycles   = 2097151
) (
    input  logic                    sysclk,
    input  logic                    reset,

    // Host command stream
    input  logic                    hostValid,
    output logic                    hostReady,
    input  logic [HostWordBits-1:0] hostWord,

    // Read results
    output logic                    rspValid,
    input  logic                    rspReady,
    output kszRsp_t                 rsp,

    output logic                    chipReady,
    output logic                    badCmd,

    // Chip pins, bus split for an external resolver
    output logic                    ethRstn,
    output logic                    ethCmd,
    output logic                    ethRdn,
    output logic                    ethWrn,
    output logic [15:0]             sdOut,
    output logic                    sdOe,
    input  logic [15:0]             sdIn
);

    logic    cmdInValid;    // Decoder to command FIFO
    logic    cmdInReady;
    kszCmd_t cmdIn;
    logic    cmdOutValid;   // Command FIFO to controller
    logic    cmdOutReady;
    kszCmd_t cmdOut;
    logic    rspInValid;    // Controller to response FIFO
    logic    rspInReady;
    kszRsp_t rspIn;

    hostCmdDecode hostCmdDecode_i (
        .sysclk, .reset,
        .hostValid, .hostWord, .hostReady,
        .cmdValid (cmdInValid), .cmd (cmdIn), .cmdReady (cmdInReady),
        .badCmd
    );

    syncFifo #(.ItemT(kszCmd_t), .Depth(CmdDepth)) cmdFifo_i (
        .sysclk, .reset,
        .inValid  (cmdInValid),  .inData  (cmdIn),  .inReady  (cmdInReady),
        .outValid (cmdOutValid), .outData (cmdOut), .outReady (cmdOutReady)
    );

    kszBusCtrl #(
        .ResetAssertCycles (ResetAssertCycles),
        .ResetWaitCycles   (ResetWaitCycles)
    ) kszBusCtrl_i (
        .sysclk, .reset,
        .cmdValid (cmdOutValid), .cmd (cmdOut), .cmdReady (cmdOutReady),
        .rspValid (rspInValid),  .rsp (rspIn),  .rspReady (rspInReady),
        .chipReady,
        .ethRstn, .ethCmd, .ethRdn, .ethWrn,
        .sdOut, .sdOe, .sdIn
    );

    syncFifo #(.ItemT(kszRsp_t), .Depth(RspDepth)) rspFifo_i (
        .sysclk, .reset,
        .inValid  (rspInValid), .inData  (rspIn), .inReady  (rspInReady),
        .outValid (rspValid),   .outData (rsp),   .outReady (rspReady)
    );

endmodule

// File: verilog/kszPkg.sv
/*
 * KSZ8851 bus master shared definitions
 * Host command word layout, the typed command and response records
 * and the operation kinds used between decoder, FIFOs and bus controller
 */

package kszPkg;

    // ------------------------------------------------------------------------
    // Host command word fields
    // ------------------------------------------------------------------------
    localparam int HostWordBits = 32;   // Width of one host command word

    localparam int RsvdMsb    = 31;     // Reserved field, must be zero
    localparam int RsvdLsb    = 28;
    localparam int DmaBit     = 27;     // Data access without address cycle
    localparam int ChipRstBit = 26;     // Pulse the chip reset pin
    localparam int WriteBit   = 25;     // 1 write, 0 read
    localparam int WordBit    = 24;     // 1 word (16 bit), 0 byte
    localparam int OffsMsb    = 23;     // Register offset
    localparam int OffsLsb    = 16;
    localparam int DataMsb    = 15;     // Write data
    localparam int DataLsb    = 0;

    // Kind of bus operation
    typedef enum logic [1:0] {
        opReg       = 2'd0,             // Address cycle then data cycle
        opDma       = 2'd1,             // Data cycle only
        opChipReset = 2'd2              // Reset pulse plus wake-up wait
    } kszOp_t;

    // Decoded command, 28 bits
    typedef struct packed {
        kszOp_t      op;
        logic        isWrite;
        logic        isWord;
        logic [7:0]  regAddr;           // Register offset 0x00-0xFF
        logic [15:0] data;              // Write data, ignored on reads
    } kszCmd_t;

    // Read result
    typedef struct packed {
        logic [15:0] rdData;            // Value sampled from the bus
        logic        wasDma;            // Came from a DMA read
    } kszRsp_t;

endpackage

// File: verilog/syncFifo.sv
/*
 * Synchronous FIFO
 * Circular buffer for any packed payload, valid/ready on both sides.
 * One cycle from write to output, push and pop together when full
 */

`timescale 1ns/1ps

module syncFifo #(
    parameter type ItemT = logic [15:0],    // Payload record
    parameter int  Depth = 4                // Number of entries
) (
    input  logic sysclk,
    input  logic reset,

    input  logic inValid,
    input  ItemT inData,
    output logic inReady,

    output logic outValid,
    output ItemT outData,
    input  logic outReady
);

    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = $clog2(Depth + 1);

    ItemT            mem [Depth];       // Storage, no reset
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;             // Occupancy
    logic [CntW-1:0] countNext;
    logic            notFull;           // Registered, low out of reset
    logic            push;
    logic            pop;

    // Pointer advance with wrap at Depth
    function automatic logic [PtrW-1:0] bump(input logic [PtrW-1:0] p);
        return (p == PtrW'(Depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign outValid = (count != '0);
    assign outData  = mem[rdPtr];
    assign pop      = outValid && outReady;
    assign inReady  = notFull || pop;   // Full but draining still takes one
    assign push     = inValid && inReady;

    always_comb begin
        countNext = count;
        case ({push, pop})
            2'b10:   countNext = count + 1'b1;
            2'b01:   countNext = count - 1'b1;
            default: countNext = count;     // Idle or both
        endcase
    end

    always_ff @(posedge sysclk or negedge reset) begin
        if (!reset) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            count   <= '0;
            notFull <= 1'b0;
        end else begin
            if (push) wrPtr <= bump(wrPtr);
            if (pop)  rdPtr <= bump(rdPtr);
            count   <= countNext;
            notFull <= (countNext != CntW'(Depth));
        end
    end

    always_ff @(posedge sysclk) begin
        if (push) mem[wrPtr] <= inData;     // Payload write
    end

    // ------------------------------------------------------------------------
    // Occupancy checks
    // ------------------------------------------------------------------------
    noOverflow: assert property (
        @(posedge sysclk) disable iff (!reset) count <= CntW'(Depth)
    );
    // Empty means the read pointer has caught up with the write pointer, never passed it
    noUnderflow: assert property (
        @(posedge sysclk) disable iff (!reset)
        count == '0 |-> rdPtr == wrPtr
    );

endmodule

// File: vlog.f
verilog/kszPkg.sv
verilog/hostCmdDecode.sv
verilog/syncFifo.sv
verilog/kszBusCtrl.sv
verilog/kszBusTop.sv
tb/kszChipModel.sv
tb/tbKszBus.sv
